//--- dv/gmii_link_tb.sv
/* Testbench for the GMII PCS link
   Serdes loopback, negotiation, frames, error marking, loss of signal and bypass */
`timescale 1ns/1ns
`include "pcs_params.svh"

module gmii_link_tb;
	import pcs_an_pkg::*;

	localparam logic [15:0] ACK_WORD = `PCS_ABILITY | (16'h1 << `PCS_ACK_BIT);
	localparam int AN_LIMIT = 8 * `PCS_LINK_TIMER; // Negotiation bound in cycles

	logic        GTX_CLK;
	logic        arst_n;
	logic        rst_req;
	logic [7:0]  TXD;
	logic        TX_EN;
	logic        TX_ER;
	logic [9:0]  txdata;
	logic [9:0]  rxdata;
	logic        corrupt;     // Flip bit 0 of the looped-back word
	logic        rx_los;
	logic        an_bypass;
	logic [7:0]  RXD;
	logic        RX_DV;
	logic        RX_ER;
	logic        operate;
	an_state_e   an_state_mon;
	logic [15:0] lacr_rx;
	logic [7:0]  exp_q [$];   // Expected RXD bytes in order
	logic [7:0]  exp_b;
	logic        err_mode;    // Error frame where only RX_ER is watched
	logic        er_seen;
	logic        dv_prev;
	int          frames_sent;
	int          frames_seen;
	int          mismatches;
	int          failures;
	integer      seed;
	string       test_name;

	assign rxdata = corrupt ? (txdata ^ 10'h001) : txdata; // Serdes loopback

	tb_clk_gen clk_gen (.rst_req(rst_req), .GTX_CLK(GTX_CLK), .arst_n(arst_n));

	gmii_link dut (.GTX_CLK(GTX_CLK), .arst_n(arst_n), .TXD(TXD), .TX_EN(TX_EN),
		.TX_ER(TX_ER), .rxdata(rxdata), .rx_los(rx_los), .an_bypass(an_bypass),
		.txdata(txdata), .RXD(RXD), .RX_DV(RX_DV), .RX_ER(RX_ER), .operate(operate),
		.an_state_mon(an_state_mon), .lacr_rx(lacr_rx));

	bind gmii_link pcs_checker chk (.GTX_CLK(GTX_CLK), .arst_n(arst_n), .txdata(txdata),
		.RX_DV(RX_DV), .operate(operate));

	// Expected RXD byte at a frame position with /S/ rebuilt as preamble
	function automatic logic [7:0] expected_rxd(input logic [7:0] tx_byte, input int pos);
		if (pos == 0)
			return 8'h55;
		return tx_byte;
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		mismatches++;
		$display("FAIL %s: expected %h, actual %h", name, exp_v, act_v);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("ERROR: %s", what);
	endtask

	// Compare on the falling edge where RX outputs are settled
	always @(negedge GTX_CLK) begin
		if (arst_n && dv_prev && !RX_DV)
			frames_seen++; // Frame closed by /T/
		if (arst_n && RX_DV && err_mode) begin
			if (RX_ER)
				er_seen = 1'b1;
		end else if (arst_n && RX_DV) begin
			assert (exp_q.size() != 0) else
				report_failure({test_name, ": RXD byte with no byte expected"});
			if (exp_q.size() != 0) begin
				exp_b = exp_q.pop_front();
				assert (RXD == exp_b) else
					report_mismatch({test_name, " RXD"}, exp_b, RXD);
				assert (!RX_ER) else
					report_mismatch({test_name, " RX_ER"}, 0, RX_ER);
			end
		end
		dv_prev = RX_DV;
	end

	task automatic wait_reset_release(input int limit);
		int n;
		n = 0;
		while (arst_n !== 1'b1 && n < limit) begin
			@(posedge GTX_CLK);
			n++;
		end
		assert (arst_n === 1'b1) else report_failure("reset never released");
		@(negedge GTX_CLK);
	endtask

	task automatic wait_operate(input logic level, input int limit);
		int n;
		n = 0;
		while (operate !== level && n < limit) begin
			@(negedge GTX_CLK);
			n++;
		end
		assert (operate === level) else
			report_failure($sformatf("%s: operate not %b after %0d cycles", test_name,
				level, limit));
	endtask

	task automatic wait_frames(input int limit);
		int n;
		n = 0;
		while (frames_seen != frames_sent && n < limit) begin
			@(posedge GTX_CLK); // Counter moves on the falling edge
			n++;
		end
		assert (frames_seen == frames_sent) else
			report_failure($sformatf("%s: %0d frames sent, %0d received", test_name,
				frames_sent, frames_seen));
	endtask

	// One GMII frame starting with the preamble byte and followed by an idle gap
	task automatic send_frame(input int len, input int er_pos, input int cor_pos,
		input logic zeros);
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			b = (i == 0) ? 8'h55 : (zeros ? 8'h00 : 8'($random(seed)));
			if (!err_mode)
				exp_q.push_back(expected_rxd(b, i));
			@(negedge GTX_CLK);
			TX_EN = 1'b1;
			TXD = b;
			TX_ER = (i == er_pos);
			corrupt = (i == cor_pos); // Hits the word of byte i-2
		end
		@(negedge GTX_CLK);
		TX_EN = 1'b0;
		TX_ER = 1'b0;
		corrupt = 1'b0;
		TXD = 8'h00;
		frames_sent++;
		repeat (12) @(negedge GTX_CLK);
	endtask

	task automatic run_frames(input string name, input int count);
		int len;
		test_name = name;
		for (int f = 0; f < count; f++) begin
			len = 8 + int'($unsigned($random(seed)) % 33); // 8 to 40 bytes
			send_frame(len, -1, -1, 1'b0);
		end
		wait_frames(200);
		assert (exp_q.size() == 0) else
			report_failure($sformatf("%s: %0d bytes never arrived", name, exp_q.size()));
	endtask

	task automatic error_frame(input string name, input int er_pos, input int cor_pos,
		input logic zeros);
		test_name = name;
		err_mode = 1'b1;
		er_seen = 1'b0;
		send_frame(24, er_pos, cor_pos, zeros);
		wait_frames(200);
		assert (er_seen) else report_failure({name, ": RX_ER never high inside the frame"});
		err_mode = 1'b0;
	endtask

	initial begin
		seed = 60;
		TXD = 8'h00;
		TX_EN = 1'b0;
		TX_ER = 1'b0;
		rx_los = 1'b0;
		an_bypass = 1'b0;
		corrupt = 1'b0;
		rst_req = 1'b0;
		err_mode = 1'b0;
		er_seen = 1'b0;
		dv_prev = 1'b0;
		exp_b = 8'h00;
		frames_sent = 0;
		frames_seen = 0;
		mismatches = 0;
		failures = 0;
		test_name = "negotiation";

		// Self-negotiation through the loopback
		wait_reset_release(20);
		assert (operate == 1'b0) else report_mismatch("reset operate", 0, operate);
		assert (an_state_mon == AN_RESTART) else
			report_mismatch("reset state", AN_RESTART, an_state_mon);
		wait_operate(1'b1, AN_LIMIT);
		assert (an_state_mon == AN_LINK_OK) else
			report_mismatch("negotiation state", AN_LINK_OK, an_state_mon);
		assert (lacr_rx == ACK_WORD) else
			report_mismatch("negotiation lacr_rx", ACK_WORD, lacr_rx);

		run_frames("frames", 6);

		error_frame("tx_er frame", 6, -1, 1'b0);
		error_frame("corrupt frame", -1, 12, 1'b1); // Zero payload

		// Loss of signal and renegotiation
		test_name = "rx_los";
		@(negedge GTX_CLK);
		rx_los = 1'b1;
		wait_operate(1'b0, 10);
		assert (an_state_mon == AN_RESTART) else
			report_mismatch("rx_los state", AN_RESTART, an_state_mon);
		repeat (10) @(negedge GTX_CLK);
		rx_los = 1'b0;
		wait_operate(1'b1, AN_LIMIT);
		assert (an_state_mon == AN_LINK_OK) else
			report_mismatch("relink state", AN_LINK_OK, an_state_mon);
		assert (lacr_rx == ACK_WORD) else
			report_mismatch("relink lacr_rx", ACK_WORD, lacr_rx);
		run_frames("relink frames", 2);

		// Bypass from a fresh reset without any config exchange
		test_name = "bypass";
		@(negedge GTX_CLK);
		an_bypass = 1'b1;
		rst_req = 1'b1;
		@(negedge GTX_CLK);
		rst_req = 1'b0;
		wait_reset_release(20);
		assert (operate == 1'b0) else report_mismatch("bypass reset operate", 0, operate);
		wait_operate(1'b1, AN_LIMIT);
		assert (lacr_rx == 16'h0000) else report_mismatch("bypass lacr_rx", 16'h0000, lacr_rx);
		assert (an_state_mon == AN_LINK_OK) else
			report_mismatch("bypass state", AN_LINK_OK, an_state_mon);
		run_frames("bypass frames", 4);

		$display("Error count: %0d value mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, dut.chk.fail_cnt);
		if (mismatches == 0 && failures == 0 && dut.chk.fail_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- dv/pcs_checker.sv
/* PCS assertion checker
   Code-group weight, disparity alternation and reset state of the link */
`timescale 1ns/1ns

module pcs_checker (
	input logic       GTX_CLK,
	input logic       arst_n,
	input logic [9:0] txdata,
	input logic       RX_DV,
	input logic       operate
);
	int   fail_cnt = 0; // Assertion failures so far
	logic unb;
	logic pos;
	logic last_pos;     // Sign of the last unbalanced word
	logic armed;        // Low while the reset word is still on txdata

	assign unb = ($countones(txdata) != 5);
	assign pos = ($countones(txdata) > 5);

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			armed <= 1'b0;
			last_pos <= 1'b0; // Encoder starts at RD-
		end else begin
			armed <= 1'b1;
			if (armed && unb)
				last_pos <= pos;
		end
	end

	balance: assert property (@(posedge GTX_CLK) disable iff (!arst_n)
		($countones(txdata) >= 4 && $countones(txdata) <= 6))
		else begin
			fail_cnt++;
			$error("txdata %b has a weight no code group can have", txdata);
		end

	alternate: assert property (@(posedge GTX_CLK) disable iff (!arst_n)
		(armed && unb) |-> (pos != last_pos))
		else begin
			fail_cnt++;
			$error("Two unbalanced code groups of the same sign in a row");
		end

	// First outputs computed after release stay low
	reset_state: assert property (@(posedge GTX_CLK) $rose(arst_n) |=> (!RX_DV && !operate))
		else begin
			fail_cnt++;
			$error("RX_DV or operate high right after reset");
		end

endmodule

//--- dv/tb_clk_gen.sv
/* Testbench clock and reset source
   40 ns GTX_CLK, reset held for 3 cycles at start and on request */
`timescale 1ns/1ns

module tb_clk_gen (
	input  logic rst_req,
	output logic GTX_CLK,
	output logic arst_n
);
	initial GTX_CLK = 1'b0;
	always #20 GTX_CLK = ~GTX_CLK; // 40 ns period

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge GTX_CLK);
		@(negedge GTX_CLK);
		arst_n = 1'b1; // Released away from the active edge
	end

	// Later resets, same length
	always @(posedge rst_req) begin
		arst_n = 1'b0;
		repeat (3) @(posedge GTX_CLK);
		@(negedge GTX_CLK);
		arst_n = 1'b1;
	end

endmodule

//--- src.f
+incdir+verilog
verilog/pcs_code_pkg.sv
verilog/pcs_an_pkg.sv
verilog/enc_8b10b.sv
verilog/dec_8b10b.sv
verilog/pcs_tx.sv
verilog/pcs_rx.sv
verilog/an_fsm.sv
verilog/link_timer.sv
verilog/gmii_link.sv
dv/tb_clk_gen.sv
dv/pcs_checker.sv
dv/gmii_link_tb.sv

//--- verilog/an_fsm.sv
/* Auto-negotiation FSM
   Exchanges config words through the PCS and raises operate at link up */
`timescale 1ns/1ns
`include "pcs_params.svh"

module an_fsm (
	input  logic                  GTX_CLK,
	input  logic                  arst_n,
	input  logic                  an_bypass,
	input  logic                  rx_los,
	input  logic                  cfg_rx_stb,
	input  logic [15:0]           cfg_rx_val,
	input  logic                  timer_done,
	output logic                  cfg_send,
	output logic [15:0]           cfg_word,
	output logic                  timer_load,
	output logic [15:0]           timer_len,
	output logic                  operate,
	output pcs_an_pkg::an_state_e an_state_mon
);
	import pcs_an_pkg::*;

	an_state_e   state;
	logic [1:0]  match_cnt; // Repeats of the same partner word
	logic [15:0] last_rx;
	logic        tmr_exp;

	assign timer_len = 16'(`PCS_LINK_TIMER);
	assign tmr_exp = timer_done && !timer_load; // Done is stale in the load cycle
	assign an_state_mon = state;
	assign cfg_word = (state == AN_RESTART) ? 16'h0000 :
		(state == AN_ABILITY) ? `PCS_ABILITY : (`PCS_ABILITY | (16'h1 << `PCS_ACK_BIT));

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= AN_RESTART;
			timer_load <= 1'b1; // Restart period begins out of reset
			operate <= 1'b0;
			cfg_send <= 1'b0;
			match_cnt <= 2'd0;
			last_rx <= 16'h0000;
		end else begin
			timer_load <= 1'b0;
			if (rx_los) begin
				if (state != AN_RESTART)
					timer_load <= 1'b1;
				state <= AN_RESTART;
				operate <= 1'b0;
				cfg_send <= 1'b0;
				match_cnt <= 2'd0;
			end else begin
				case (state)
					AN_RESTART: begin
						cfg_send <= !an_bypass;
						if (an_bypass) begin
							state <= AN_LINK_OK;
							timer_load <= 1'b1;
						end else if (tmr_exp)
							state <= AN_ABILITY;
					end
					AN_ABILITY: if (cfg_rx_stb) begin
						last_rx <= cfg_rx_val;
						if (cfg_rx_val != 16'h0000 && cfg_rx_val == last_rx) begin
							match_cnt <= match_cnt + 2'd1;
							if (match_cnt == 2'd1)
								state <= AN_ACK; // Third equal word
						end else
							match_cnt <= 2'd0;
					end
					AN_ACK: if (cfg_rx_stb && cfg_rx_val[`PCS_ACK_BIT]) begin
						state <= AN_LINK_OK;
						timer_load <= 1'b1;
					end
					default: if (tmr_exp) begin
						operate <= 1'b1;
						cfg_send <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

//--- verilog/dec_8b10b.sv
/* 8b/10b decoder
   Inverse table lookup with code and running disparity checks, registered */
`timescale 1ns/1ns

module dec_8b10b (
	input  logic       GTX_CLK,
	input  logic       arst_n,
	input  logic [9:0] rxdata,
	output logic [7:0] dec_data,
	output logic       dec_is_k,
	output logic       code_err,
	output logic       disp_err
);
	import pcs_code_pkg::*;

	logic       rd;    // Running disparity, 1 is positive
	logic [5:0] c6;
	logic [3:0] c4;
	logic [3:0] c4a;
	logic [4:0] x;
	logic [2:0] y;
	logic       is28;
	logic       a7;
	logic       v6;
	logic       v4;
	logic       rd6;
	logic       rd_nxt;
	logic       derr;

	assign c6 = rxdata[9:4];
	assign c4 = rxdata[3:0];
	assign is28 = (c6 == 6'b001111) || (c6 == 6'b110000);
	// K28 from RD+ carries the balanced 4b forms inverted
	assign c4a = (c6 == 6'b110000 && $countones(c4) == 2 && c4 != 4'b1100 &&
		c4 != 4'b0011) ? ~c4 : c4;
	assign a7 = (c4a == 4'b0111) || (c4a == 4'b1000);

	always_comb begin
		x = 5'd28;
		v6 = is28;
		for (int i = 0; i < 32; i++) begin
			if (c6 == TAB6[i] || (($countones(TAB6[i]) != 3 || i == 7) && c6 == ~TAB6[i])) begin
				x = i[4:0];
				v6 = 1'b1;
			end
		end
		y = 3'd7;
		v4 = a7;
		for (int j = 0; j < 8; j++) begin
			if (c4a == TAB4[j] || (($countones(TAB4[j]) != 2 || j == 3) && c4a == ~TAB4[j])) begin
				y = j[2:0];
				v4 = 1'b1;
			end
		end
	end

	// RD follows the sign of the last unbalanced sub-block
	assign rd6 = ($countones(c6) > 3) ? 1'b1 : ($countones(c6) < 3) ? 1'b0 : rd;
	assign rd_nxt = ($countones(c4) > 2) ? 1'b1 : ($countones(c4) < 2) ? 1'b0 : rd6;
	assign derr = (!rd && ($countones(c6) < 3 || c6 == 6'b000111)) ||
		(rd && ($countones(c6) > 3 || c6 == 6'b111000)) ||
		(!rd6 && ($countones(c4) < 2 || c4 == 4'b0011)) ||
		(rd6 && ($countones(c4) > 2 || c4 == 4'b1100));

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			rd <= 1'b0;
			dec_data <= 8'h00;
			dec_is_k <= 1'b0;
			code_err <= 1'b0;
			disp_err <= 1'b0;
		end else begin
			rd <= rd_nxt;
			dec_data <= {y, x};
			dec_is_k <= is28 || (a7 && (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30));
			code_err <= !v6 || !v4;
			disp_err <= derr;
		end
	end

endmodule

//--- verilog/enc_8b10b.sv
/* 8b/10b encoder
   Table coding of 5b/6b and 3b/4b sub-blocks with running disparity, registered */
`timescale 1ns/1ns

module enc_8b10b (
	input  logic       GTX_CLK,
	input  logic       arst_n,
	input  logic [7:0] tx_code,
	input  logic       tx_is_k,
	output logic [9:0] txdata,
	output logic       tx_rd
);
	import pcs_code_pkg::*;

	logic [4:0] x;
	logic [2:0] y;
	logic       k28;
	logic [5:0] c6n;
	logic [5:0] c6;
	logic       unb6;
	logic       rd6;
	logic       alt7;
	logic [3:0] c4n;
	logic [3:0] c4;
	logic       unb4;

	assign x = tx_code[4:0];
	assign y = tx_code[7:5];
	assign k28 = tx_is_k && (x == 5'd28);

	// 6b sub-block
	assign c6n = k28 ? 6'b001111 : TAB6[x];
	assign unb6 = ($countones(c6n) != 3);
	// D7 is balanced but still has two forms
	assign c6 = (tx_rd && (unb6 || (x == 5'd7 && !k28))) ? ~c6n : c6n;
	assign rd6 = unb6 ? ~tx_rd : tx_rd; // Unbalanced block always flips RD

	// Alternate x.7 avoids a run of five
	assign alt7 = tx_is_k ||
		(!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
		(rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14));
	assign c4n = (y == 3'd7 && alt7) ? 4'b0111 : TAB4[y];
	assign unb4 = ($countones(c4n) != 2);
	// K28 inverts balanced 4b forms when entered from RD+
	assign c4 = ((rd6 && (unb4 || y == 3'd3)) ||
		(k28 && !rd6 && !unb4 && y != 3'd3)) ? ~c4n : c4n;

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			txdata <= 10'b0011111010; // K28.5 RD-
			tx_rd <= 1'b0;            // Start negative
		end else begin
			txdata <= {c6, c4};
			tx_rd <= unb4 ? ~rd6 : rd6;
		end
	end

endmodule

//--- verilog/gmii_link.sv
/* 1000BASE-X PCS top, PHY side of a GMII link
   Transmit and receive paths, auto-negotiation and link timer on GTX_CLK */
`timescale 1ns/1ns

module gmii_link (
	input  logic                  GTX_CLK,
	input  logic                  arst_n,
	input  logic [7:0]            TXD,
	input  logic                  TX_EN,
	input  logic                  TX_ER,
	input  logic [9:0]            rxdata,
	input  logic                  rx_los,
	input  logic                  an_bypass,
	output logic [9:0]            txdata,
	output logic [7:0]            RXD,
	output logic                  RX_DV,
	output logic                  RX_ER,
	output logic                  operate,
	output pcs_an_pkg::an_state_e an_state_mon,
	output logic [15:0]           lacr_rx
);
	logic [7:0]  tx_code;
	logic        tx_is_k;
	logic        tx_rd;
	logic [7:0]  dec_data;
	logic        dec_is_k;
	logic        code_err;
	logic        disp_err;
	logic        cfg_send;
	logic [15:0] cfg_word;
	logic        cfg_rx_stb;
	logic        timer_load;
	logic [15:0] timer_len;
	logic        timer_done;

	pcs_tx u_tx (.GTX_CLK, .arst_n, .TXD, .TX_EN, .TX_ER, .cfg_send, .cfg_word,
		.tx_rd, .tx_code, .tx_is_k);

	enc_8b10b u_enc (.GTX_CLK, .arst_n, .tx_code, .tx_is_k, .txdata, .tx_rd);

	dec_8b10b u_dec (.GTX_CLK, .arst_n, .rxdata, .dec_data, .dec_is_k, .code_err, .disp_err);

	// Received config word doubles as the lacr monitor
	pcs_rx u_rx (.GTX_CLK, .arst_n, .dec_data, .dec_is_k, .code_err, .disp_err, .rx_los,
		.RXD, .RX_DV, .RX_ER, .cfg_rx_stb, .cfg_rx_val(lacr_rx));

	an_fsm u_an (.GTX_CLK, .arst_n, .an_bypass, .rx_los, .cfg_rx_stb, .cfg_rx_val(lacr_rx),
		.timer_done, .cfg_send, .cfg_word, .timer_load, .timer_len, .operate, .an_state_mon);

	link_timer u_timer (.GTX_CLK, .arst_n, .timer_load, .timer_len, .timer_done);

endmodule

//--- verilog/link_timer.sv
/* Link timer
   Loadable down-counter, done level held at zero until the next load */
`timescale 1ns/1ns

module link_timer (
	input  logic        GTX_CLK,
	input  logic        arst_n,
	input  logic        timer_load,
	input  logic [15:0] timer_len,
	output logic        timer_done
);
	logic [15:0] count;

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n)
			count <= 16'd0;
		else if (timer_load)
			count <= timer_len;
		else if (count != 16'd0)
			count <= count - 16'd1; // Stops at zero
	end

	assign timer_done = (count == 16'd0);

endmodule

//--- verilog/pcs_an_pkg.sv
/* Auto-negotiation definitions
   Negotiation state encoding shared by the FSM and the top level */
package pcs_an_pkg;

	typedef enum logic [1:0] {
		AN_RESTART, // Sending zero config for one timer period
		AN_ABILITY, // Sending ability, waiting for a stable partner word
		AN_ACK,     // Sending ability with ack
		AN_LINK_OK  // Link up, operate after one more timer period
	} an_state_e;

endpackage

//--- verilog/pcs_code_pkg.sv
/* Code-level definitions for the PCS
   Special characters, transmit ordered-set opcodes, 8b/10b RD- tables */
package pcs_code_pkg;

	typedef enum logic [7:0] {
		K28_5 = 8'hBC, // Comma
		K27_7 = 8'hFB, // Start of packet /S/
		K29_7 = 8'hFD, // End of packet /T/
		K23_7 = 8'hF7, // Carrier extend /R/
		K30_7 = 8'hFE  // Error propagation /V/
	} kchar_e;

	typedef enum logic [2:0] {
		OS_IDLE, OS_CONFIG, OS_START, OS_DATA, OS_END, OS_EXT
	} tx_os_e;

	// Idle and config second code groups
	localparam logic [7:0] D5_6 = 8'hC5;
	localparam logic [7:0] D16_2 = 8'h50;
	localparam logic [7:0] D21_5 = 8'hB5;
	localparam logic [7:0] D2_2 = 8'h42;

	// 5b/6b codes abcdei, RD- column, index is EDCBA
	localparam logic [5:0] TAB6 [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001,
		6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100,
		6'b011100, 6'b010111, 6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011,
		6'b101010, 6'b011010, 6'b111010, 6'b110011, 6'b100110, 6'b010110, 6'b110110,
		6'b001110, 6'b101110, 6'b011110, 6'b101011};

	// 3b/4b codes fghj, RD- column, x.7 is the primary form
	localparam logic [3:0] TAB4 [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};

endpackage

//--- verilog/pcs_params.svh
/* PCS build constants
   Link timer length, local ability word, ack bit position */
`ifndef PCS_PARAMS_SVH
`define PCS_PARAMS_SVH

// Link timer in GTX_CLK cycles, short for simulation
`define PCS_LINK_TIMER 64

// Local ability, full duplex only (bit 5)
`define PCS_ABILITY 16'h0020

`define PCS_ACK_BIT 14 // Ack bit in the config word

`endif

//--- verilog/pcs_rx.sv
/* Receive ordered-set parser
   Rebuilds GMII receive signals and captures config words */
`timescale 1ns/1ns

module pcs_rx (
	input  logic        GTX_CLK,
	input  logic        arst_n,
	input  logic [7:0]  dec_data,
	input  logic        dec_is_k,
	input  logic        code_err,
	input  logic        disp_err,
	input  logic        rx_los,
	output logic [7:0]  RXD,
	output logic        RX_DV,
	output logic        RX_ER,
	output logic        cfg_rx_stb,
	output logic [15:0] cfg_rx_val
);
	import pcs_code_pkg::*;

	logic [1:0] idx;     // Position after the last comma
	logic [7:0] cfg_lo;
	logic       err;

	assign err = code_err | disp_err;

	always_ff @(posedge GTX_CLK) begin
		if (idx == 2'd2)
			cfg_lo <= dec_data;
	end

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			RXD <= 8'h00;
			RX_DV <= 1'b0;
			RX_ER <= 1'b0;
			cfg_rx_stb <= 1'b0;
			cfg_rx_val <= 16'h0000;
			idx <= 2'd0;
		end else begin
			cfg_rx_stb <= 1'b0;
			if (rx_los) begin
				RX_DV <= 1'b0;
				RX_ER <= 1'b0;
				idx <= 2'd0;
			end else if (RX_DV) begin
				idx <= 2'd0;
				// /T/ ends the frame, a comma means the end was lost
				if (dec_is_k && (dec_data == K29_7 || dec_data == K28_5)) begin
					RX_DV <= 1'b0;
					RX_ER <= 1'b0;
				end else begin
					RXD <= dec_data;
					RX_ER <= err | dec_is_k; // /V/ or any stray K
				end
			end else if (dec_is_k && dec_data == K27_7) begin
				RX_DV <= 1'b1;
				RXD <= 8'h55; // /S/ stands for the first preamble byte
				RX_ER <= err;
				idx <= 2'd0;
			end else begin
				RX_ER <= 1'b0;
				if (dec_is_k && dec_data == K28_5 && !err)
					idx <= 2'd1;
				else if (err || dec_is_k)
					idx <= 2'd0;
				else begin
					case (idx)
						2'd1: idx <= (dec_data == D21_5 || dec_data == D2_2) ? 2'd2 : 2'd0;
						2'd2: idx <= 2'd3;
						2'd3: begin
							cfg_rx_val <= {dec_data, cfg_lo};
							cfg_rx_stb <= 1'b1;
							idx <= 2'd0;
						end
						default: idx <= 2'd0; // Idle, nothing to collect
					endcase
				end
			end
		end
	end

endmodule

//--- verilog/pcs_tx.sv
/* Transmit ordered-set generator
   GMII frames and config requests in, code groups for the encoder out */
`timescale 1ns/1ns

module pcs_tx (
	input  logic        GTX_CLK,
	input  logic        arst_n,
	input  logic [7:0]  TXD,
	input  logic        TX_EN,
	input  logic        TX_ER,
	input  logic        cfg_send,
	input  logic [15:0] cfg_word,
	input  logic        tx_rd,
	output logic [7:0]  tx_code,
	output logic        tx_is_k
);
	import pcs_code_pkg::*;

	tx_os_e      os;       // Set currently being sent
	logic        odd;      // Group in tx_code sits at an odd position
	logic        tx_en_q;
	logic        c_alt;    // /C1/ or /C2/
	logic [1:0]  cnt;      // Group index inside a config set
	logic [15:0] cfg_hold;

	always_ff @(posedge GTX_CLK) begin
		if (os != OS_CONFIG || cnt == 2'd3)
			cfg_hold <= cfg_word; // Word frozen for the whole set
	end

	always_ff @(posedge GTX_CLK or negedge arst_n) begin
		if (!arst_n) begin
			os <= OS_IDLE;
			odd <= 1'b0;
			tx_en_q <= 1'b0;
			c_alt <= 1'b0;
			cnt <= 2'd0;
			tx_code <= K28_5;
			tx_is_k <= 1'b1;
		end else begin
			tx_en_q <= TX_EN;
			odd <= ~odd;
			if (TX_EN && !tx_en_q) begin
				os <= OS_START; // /S/ replaces the first byte
				tx_code <= K27_7;
				tx_is_k <= 1'b1;
			end else if (TX_EN) begin
				os <= OS_DATA;
				tx_code <= TX_ER ? K30_7 : TXD;
				tx_is_k <= TX_ER;
			end else if (tx_en_q) begin
				os <= OS_END;
				tx_code <= K29_7;
				tx_is_k <= 1'b1;
			end else if (os == OS_END || (os == OS_EXT && !odd)) begin
				os <= OS_EXT; // Second /R/ only to reach even position
				tx_code <= K23_7;
				tx_is_k <= 1'b1;
			end else if (os == OS_CONFIG && cnt != 2'd3) begin
				cnt <= cnt + 2'd1;
				tx_is_k <= 1'b0;
				case (cnt)
					2'd0: tx_code <= c_alt ? D2_2 : D21_5;
					2'd1: tx_code <= cfg_hold[7:0];
					default: begin
						tx_code <= cfg_hold[15:8];
						c_alt <= ~c_alt;
					end
				endcase
			end else if (os == OS_IDLE && !odd) begin
				tx_code <= tx_rd ? D5_6 : D16_2; // Leave RD negative
				tx_is_k <= 1'b0;
			end else begin
				os <= cfg_send ? OS_CONFIG : OS_IDLE; // New set at even position
				cnt <= 2'd0;
				tx_code <= K28_5;
				tx_is_k <= 1'b1;
			end
		end
	end

endmodule
